// ==== src/k423_pkg.sv ====
// shared widths, word types, kept opcodes and the alu and branch operation enums

package k423_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int XLEN      = 32;
  localparam int ADDR_W    = 32;
  localparam int INST_W    = 32;
  localparam int REG_IDX_W = 5;

  // architectural registers, x0 included
  localparam int NUM_REGS = 32;

  // ------------------------------
  // word types
  // ------------------------------
  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [INST_W-1:0]    inst_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // ------------------------------
  // major opcodes that are kept
  // ------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // ------------------------------
  // operation enums
  // ------------------------------
  // pass_b forwards operand b untouched, used by lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  // branch condition, jump means always taken
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_JUMP
  } br_op_e;

endpackage

// ==== src/k423_fetch.sv ====
// fetch stage with program counter, branch redirect and fetch-to-decode register

module k423_fetch #(
  parameter k423_pkg::addr_t RESET_PC = '0
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  // redirect from execute
  input  logic             br_tkn_i,
  input  k423_pkg::addr_t  br_pc_i,
  // instruction memory
  output k423_pkg::addr_t  imem_addr_o,
  input  k423_pkg::inst_t  imem_rdata_i,
  // to decode
  output logic             if_vld_o,
  output k423_pkg::addr_t  if_pc_o,
  output k423_pkg::inst_t  if_inst_o
);

  k423_pkg::addr_t pc_q;
  k423_pkg::addr_t pc_nxt;

  logic            if_vld_q;
  k423_pkg::addr_t if_pc_q;
  k423_pkg::inst_t if_inst_q;

  // ------------------------------
  // program counter
  // ------------------------------
  // sequential unless execute resolves a taken branch or jal
  assign pc_nxt = br_tkn_i ? br_pc_i : pc_q + 32'd4;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_nxt;
    end
  end

  assign imem_addr_o = pc_q;

  // ------------------------------
  // fetch-to-decode register
  // ------------------------------
  // the word fetched under a redirect is wrong path
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      if_vld_q <= 1'b0;
    end else begin
      if_vld_q <= ~br_tkn_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if_pc_q   <= pc_q;
    if_inst_q <= imem_rdata_i;
  end

  assign if_vld_o  = if_vld_q;
  assign if_pc_o   = if_pc_q;
  assign if_inst_o = if_inst_q;

endmodule

// ==== src/k423_decode.sv ====
// instruction decoder, immediate generation and decode-to-execute register

module k423_decode (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                br_tkn_i,
  // from fetch
  input  logic                if_vld_i,
  input  k423_pkg::addr_t     if_pc_i,
  input  k423_pkg::inst_t     if_inst_i,
  // register read
  output k423_pkg::reg_idx_t  rs1_idx_o,
  output k423_pkg::reg_idx_t  rs2_idx_o,
  input  k423_pkg::xlen_t     rs1_data_i,
  input  k423_pkg::xlen_t     rs2_data_i,
  // to execute
  output logic                id_vld_o,
  output k423_pkg::addr_t     id_pc_o,
  output k423_pkg::alu_op_e   id_alu_op_o,
  output k423_pkg::br_op_e    id_br_op_o,
  output k423_pkg::xlen_t     id_op_a_o,
  output k423_pkg::xlen_t     id_op_b_o,
  output k423_pkg::xlen_t     id_rs1_o,
  output k423_pkg::xlen_t     id_rs2_o,
  output k423_pkg::xlen_t     id_imm_o,
  output logic                id_rd_vld_o,
  output k423_pkg::reg_idx_t  id_rd_idx_o
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  k423_pkg::reg_idx_t rd_idx;

  k423_pkg::xlen_t    imm_i;
  k423_pkg::xlen_t    imm_u;
  k423_pkg::xlen_t    imm_b;
  k423_pkg::xlen_t    imm_j;

  logic               f7_ok;
  k423_pkg::alu_op_e  alu_op;
  k423_pkg::br_op_e   br_op;
  k423_pkg::xlen_t    op_a;
  k423_pkg::xlen_t    op_b;
  k423_pkg::xlen_t    imm;
  logic               rd_vld;

  // ------------------------------
  // fields and immediates
  // ------------------------------
  assign opcode = if_inst_i[6:0];
  assign funct3 = if_inst_i[14:12];
  assign funct7 = if_inst_i[31:25];
  assign rd_idx = if_inst_i[11:7];

  assign rs1_idx_o = if_inst_i[19:15];
  assign rs2_idx_o = if_inst_i[24:20];

  assign imm_i = {{20{if_inst_i[31]}}, if_inst_i[31:20]};
  assign imm_u = {if_inst_i[31:12], 12'b0};
  assign imm_b = {{19{if_inst_i[31]}}, if_inst_i[31], if_inst_i[7],
                  if_inst_i[30:25], if_inst_i[11:8], 1'b0};
  assign imm_j = {{11{if_inst_i[31]}}, if_inst_i[31], if_inst_i[19:12],
                  if_inst_i[20], if_inst_i[30:21], 1'b0};

  // funct7 0x20 only exists for sub and sra
  assign f7_ok = (funct7 == 7'b0000000) ||
                 ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));

  // ------------------------------
  // decoder
  // ------------------------------
  always_comb begin
    alu_op = k423_pkg::ALU_ADD;
    br_op  = k423_pkg::BR_NONE;
    op_a   = rs1_data_i;
    op_b   = rs2_data_i;
    imm    = imm_i;
    rd_vld = 1'b0;
    case (opcode)
      k423_pkg::OPC_OP: begin
        rd_vld = f7_ok;
        case (funct3)
          3'b000:  alu_op = funct7[5] ? k423_pkg::ALU_SUB : k423_pkg::ALU_ADD;
          3'b001:  alu_op = k423_pkg::ALU_SLL;
          3'b010:  alu_op = k423_pkg::ALU_SLT;
          3'b011:  alu_op = k423_pkg::ALU_SLTU;
          3'b100:  alu_op = k423_pkg::ALU_XOR;
          3'b101:  alu_op = funct7[5] ? k423_pkg::ALU_SRA : k423_pkg::ALU_SRL;
          3'b110:  alu_op = k423_pkg::ALU_OR;
          default: alu_op = k423_pkg::ALU_AND;
        endcase
      end
      k423_pkg::OPC_OP_IMM: begin
        op_b   = imm_i;
        rd_vld = 1'b1;
        // shift immediates and sltiu are not kept
        case (funct3)
          3'b000:  alu_op = k423_pkg::ALU_ADD;
          3'b010:  alu_op = k423_pkg::ALU_SLT;
          3'b100:  alu_op = k423_pkg::ALU_XOR;
          3'b110:  alu_op = k423_pkg::ALU_OR;
          3'b111:  alu_op = k423_pkg::ALU_AND;
          default: rd_vld = 1'b0;
        endcase
      end
      k423_pkg::OPC_LUI: begin
        alu_op = k423_pkg::ALU_PASS_B;
        op_a   = '0;
        op_b   = imm_u;
        imm    = imm_u;
        rd_vld = 1'b1;
      end
      k423_pkg::OPC_BRANCH: begin
        imm = imm_b;
        case (funct3)
          3'b000:  br_op = k423_pkg::BR_EQ;
          3'b001:  br_op = k423_pkg::BR_NE;
          3'b100:  br_op = k423_pkg::BR_LT;
          3'b101:  br_op = k423_pkg::BR_GE;
          default: br_op = k423_pkg::BR_NONE;
        endcase
      end
      k423_pkg::OPC_JAL: begin
        // link address pc + 4 comes out of the alu
        op_a   = if_pc_i;
        op_b   = 32'd4;
        imm    = imm_j;
        br_op  = k423_pkg::BR_JUMP;
        rd_vld = 1'b1;
      end
      default: rd_vld = 1'b0;
    endcase
    if (rd_idx == '0) begin
      rd_vld = 1'b0;
    end
  end

  // ------------------------------
  // decode-to-execute register
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_vld_o <= 1'b0;
    end else begin
      id_vld_o <= if_vld_i & ~br_tkn_i;
    end
  end

  always_ff @(posedge clk_i) begin
    id_pc_o     <= if_pc_i;
    id_alu_op_o <= alu_op;
    id_br_op_o  <= br_op;
    id_op_a_o   <= op_a;
    id_op_b_o   <= op_b;
    id_rs1_o    <= rs1_data_i;
    id_rs2_o    <= rs2_data_i;
    id_imm_o    <= imm;
    id_rd_vld_o <= rd_vld;
    id_rd_idx_o <= rd_idx;
  end

endmodule

// ==== src/k423_regfile.sv ====
// register file with forwarding reads, writeback register and debug outputs

module k423_regfile (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // read ports for decode
  input  k423_pkg::reg_idx_t  rs1_idx_i,
  input  k423_pkg::reg_idx_t  rs2_idx_i,
  output k423_pkg::xlen_t     rs1_data_o,
  output k423_pkg::xlen_t     rs2_data_o,
  // result from execute
  input  logic                ex_rd_vld_i,
  input  k423_pkg::reg_idx_t  ex_rd_idx_i,
  input  k423_pkg::xlen_t     ex_rd_data_i,
  input  k423_pkg::addr_t     ex_pc_i,
  // retiring instruction
  output k423_pkg::addr_t     wb_pc_o,
  output logic                wb_rd_vld_o,
  output k423_pkg::reg_idx_t  wb_rd_idx_o,
  output k423_pkg::xlen_t     wb_rd_o
);

  // x0 has no storage
  k423_pkg::xlen_t    regs_q [k423_pkg::NUM_REGS-1:1];

  logic               wb_vld_q;
  k423_pkg::reg_idx_t wb_idx_q;
  k423_pkg::xlen_t    wb_data_q;
  k423_pkg::addr_t    wb_pc_q;

  // ------------------------------
  // writeback register
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_vld_q <= 1'b0;
    end else begin
      wb_vld_q <= ex_rd_vld_i;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_idx_q  <= ex_rd_idx_i;
    wb_data_q <= ex_rd_data_i;
    wb_pc_q   <= ex_pc_i;
  end

  // valid retire implies rd != 0
  always_ff @(posedge clk_i) begin
    if (wb_vld_q) begin
      regs_q[wb_idx_q] <= wb_data_q;
    end
  end

  // ------------------------------
  // reads, newest value wins
  // ------------------------------
  function automatic k423_pkg::xlen_t fwd_read(input k423_pkg::reg_idx_t idx);
    k423_pkg::xlen_t data;
    if (idx == '0) begin
      data = '0;
    end else if (ex_rd_vld_i && ex_rd_idx_i == idx) begin
      data = ex_rd_data_i;
    end else if (wb_vld_q && wb_idx_q == idx) begin
      data = wb_data_q;
    end else begin
      data = regs_q[idx];
    end
    return data;
  endfunction

  always_comb begin
    rs1_data_o = fwd_read(rs1_idx_i);
    rs2_data_o = fwd_read(rs2_idx_i);
  end

  assign wb_pc_o     = wb_pc_q;
  assign wb_rd_vld_o = wb_vld_q;
  assign wb_rd_idx_o = wb_idx_q;
  assign wb_rd_o     = wb_data_q;

endmodule

// ==== src/k423_execute.sv ====
// alu, branch and jump resolution, result toward writeback

module k423_execute (
  // from decode
  input  logic                id_vld_i,
  input  k423_pkg::addr_t     id_pc_i,
  input  k423_pkg::alu_op_e   id_alu_op_i,
  input  k423_pkg::br_op_e    id_br_op_i,
  input  k423_pkg::xlen_t     id_op_a_i,
  input  k423_pkg::xlen_t     id_op_b_i,
  input  k423_pkg::xlen_t     id_rs1_i,
  input  k423_pkg::xlen_t     id_rs2_i,
  input  k423_pkg::xlen_t     id_imm_i,
  input  logic                id_rd_vld_i,
  input  k423_pkg::reg_idx_t  id_rd_idx_i,
  // redirect
  output logic                br_tkn_o,
  output k423_pkg::addr_t     br_pc_o,
  // result
  output logic                ex_rd_vld_o,
  output k423_pkg::reg_idx_t  ex_rd_idx_o,
  output k423_pkg::xlen_t     ex_rd_data_o,
  output k423_pkg::addr_t     ex_pc_o
);

  k423_pkg::xlen_t alu_res;
  logic [4:0]      shamt;
  logic            rs_eq;
  logic            rs_lt;
  logic            take;
  k423_pkg::addr_t target;

  // ------------------------------
  // alu
  // ------------------------------
  assign shamt = id_op_b_i[4:0];

  always_comb begin
    case (id_alu_op_i)
      k423_pkg::ALU_ADD:    alu_res = id_op_a_i + id_op_b_i;
      k423_pkg::ALU_SUB:    alu_res = id_op_a_i - id_op_b_i;
      k423_pkg::ALU_AND:    alu_res = id_op_a_i & id_op_b_i;
      k423_pkg::ALU_OR:     alu_res = id_op_a_i | id_op_b_i;
      k423_pkg::ALU_XOR:    alu_res = id_op_a_i ^ id_op_b_i;
      k423_pkg::ALU_SLT:    alu_res = {31'b0, $signed(id_op_a_i) < $signed(id_op_b_i)};
      k423_pkg::ALU_SLTU:   alu_res = {31'b0, id_op_a_i < id_op_b_i};
      k423_pkg::ALU_SLL:    alu_res = id_op_a_i << shamt;
      k423_pkg::ALU_SRL:    alu_res = id_op_a_i >> shamt;
      k423_pkg::ALU_SRA:    alu_res = $signed(id_op_a_i) >>> shamt;
      k423_pkg::ALU_PASS_B: alu_res = id_op_b_i;
      default:              alu_res = '0;
    endcase
  end

  // ------------------------------
  // branch unit
  // ------------------------------
  // compares raw register values, not the alu operands
  assign rs_eq = (id_rs1_i == id_rs2_i);
  assign rs_lt = ($signed(id_rs1_i) < $signed(id_rs2_i));

  always_comb begin
    case (id_br_op_i)
      k423_pkg::BR_EQ:   take = rs_eq;
      k423_pkg::BR_NE:   take = ~rs_eq;
      k423_pkg::BR_LT:   take = rs_lt;
      k423_pkg::BR_GE:   take = ~rs_lt;
      k423_pkg::BR_JUMP: take = 1'b1;
      default:           take = 1'b0;
    endcase
  end

  // pc relative for both branches and jal
  assign target = id_pc_i + id_imm_i;

  // ------------------------------
  // outputs, only for a live instruction
  // ------------------------------
  assign br_tkn_o     = id_vld_i & take;
  assign br_pc_o      = id_vld_i ? target : '0;

  assign ex_rd_vld_o  = id_vld_i & id_rd_vld_i;
  assign ex_rd_idx_o  = id_vld_i ? id_rd_idx_i : '0;
  assign ex_rd_data_o = id_vld_i ? alu_res : '0;
  assign ex_pc_o      = id_vld_i ? id_pc_i : '0;

endmodule

// ==== src/k423_core.sv ====
// top level of the four stage core, wiring fetch, decode, execute and register file

module k423_core #(
  parameter k423_pkg::addr_t RESET_PC = '0
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // instruction memory
  output k423_pkg::addr_t     imem_addr_o,
  input  k423_pkg::inst_t     imem_rdata_i,
  // retire debug
  output k423_pkg::addr_t     debug_wb_pc_o,
  output logic                debug_wb_rd_vld_o,
  output k423_pkg::reg_idx_t  debug_wb_rd_idx_o,
  output k423_pkg::xlen_t     debug_wb_rd_o
);

  // ------------------------------
  // stage wires
  // ------------------------------
  logic               br_tkn;
  k423_pkg::addr_t    br_pc;

  logic               if_vld;
  k423_pkg::addr_t    if_pc;
  k423_pkg::inst_t    if_inst;

  k423_pkg::reg_idx_t rs1_idx;
  k423_pkg::reg_idx_t rs2_idx;
  k423_pkg::xlen_t    rs1_data;
  k423_pkg::xlen_t    rs2_data;

  logic               id_vld;
  k423_pkg::addr_t    id_pc;
  k423_pkg::alu_op_e  id_alu_op;
  k423_pkg::br_op_e   id_br_op;
  k423_pkg::xlen_t    id_op_a;
  k423_pkg::xlen_t    id_op_b;
  k423_pkg::xlen_t    id_rs1;
  k423_pkg::xlen_t    id_rs2;
  k423_pkg::xlen_t    id_imm;
  logic               id_rd_vld;
  k423_pkg::reg_idx_t id_rd_idx;

  logic               ex_rd_vld;
  k423_pkg::reg_idx_t ex_rd_idx;
  k423_pkg::xlen_t    ex_rd_data;
  k423_pkg::addr_t    ex_pc;

  // ------------------------------
  // fetch
  // ------------------------------
  k423_fetch #(
    .RESET_PC ( RESET_PC )
  ) u_k423_fetch (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .br_tkn_i     ( br_tkn       ),
    .br_pc_i      ( br_pc        ),
    .imem_addr_o  ( imem_addr_o  ),
    .imem_rdata_i ( imem_rdata_i ),
    .if_vld_o     ( if_vld       ),
    .if_pc_o      ( if_pc        ),
    .if_inst_o    ( if_inst      )
  );

  // ------------------------------
  // decode
  // ------------------------------
  k423_decode u_k423_decode (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .br_tkn_i    ( br_tkn    ),
    .if_vld_i    ( if_vld    ),
    .if_pc_i     ( if_pc     ),
    .if_inst_i   ( if_inst   ),
    .rs1_idx_o   ( rs1_idx   ),
    .rs2_idx_o   ( rs2_idx   ),
    .rs1_data_i  ( rs1_data  ),
    .rs2_data_i  ( rs2_data  ),
    .id_vld_o    ( id_vld    ),
    .id_pc_o     ( id_pc     ),
    .id_alu_op_o ( id_alu_op ),
    .id_br_op_o  ( id_br_op  ),
    .id_op_a_o   ( id_op_a   ),
    .id_op_b_o   ( id_op_b   ),
    .id_rs1_o    ( id_rs1    ),
    .id_rs2_o    ( id_rs2    ),
    .id_imm_o    ( id_imm    ),
    .id_rd_vld_o ( id_rd_vld ),
    .id_rd_idx_o ( id_rd_idx )
  );

  // ------------------------------
  // register file and retire
  // ------------------------------
  k423_regfile u_k423_regfile (
    .clk_i        ( clk_i             ),
    .arst_n_i     ( arst_n_i          ),
    .rs1_idx_i    ( rs1_idx           ),
    .rs2_idx_i    ( rs2_idx           ),
    .rs1_data_o   ( rs1_data          ),
    .rs2_data_o   ( rs2_data          ),
    .ex_rd_vld_i  ( ex_rd_vld         ),
    .ex_rd_idx_i  ( ex_rd_idx         ),
    .ex_rd_data_i ( ex_rd_data        ),
    .ex_pc_i      ( ex_pc             ),
    .wb_pc_o      ( debug_wb_pc_o     ),
    .wb_rd_vld_o  ( debug_wb_rd_vld_o ),
    .wb_rd_idx_o  ( debug_wb_rd_idx_o ),
    .wb_rd_o      ( debug_wb_rd_o     )
  );

  // ------------------------------
  // execute
  // ------------------------------
  k423_execute u_k423_execute (
    .id_vld_i     ( id_vld     ),
    .id_pc_i      ( id_pc      ),
    .id_alu_op_i  ( id_alu_op  ),
    .id_br_op_i   ( id_br_op   ),
    .id_op_a_i    ( id_op_a    ),
    .id_op_b_i    ( id_op_b    ),
    .id_rs1_i     ( id_rs1     ),
    .id_rs2_i     ( id_rs2     ),
    .id_imm_i     ( id_imm     ),
    .id_rd_vld_i  ( id_rd_vld  ),
    .id_rd_idx_i  ( id_rd_idx  ),
    .br_tkn_o     ( br_tkn     ),
    .br_pc_o      ( br_pc      ),
    .ex_rd_vld_o  ( ex_rd_vld  ),
    .ex_rd_idx_o  ( ex_rd_idx  ),
    .ex_rd_data_o ( ex_rd_data ),
    .ex_pc_o      ( ex_pc      )
  );

endmodule

// ==== sim/k423_props.sv ====
// concurrent port checks for the k423 core, bound into k423_core

module k423_props (
  input logic               clk_i,
  input logic               arst_n_i,
  input k423_pkg::addr_t    imem_addr_i,
  input logic               debug_wb_rd_vld_i,
  input k423_pkg::reg_idx_t debug_wb_rd_idx_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // fetch only issues word addresses
  imem_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    imem_addr_i[1:0] == 2'b00
  ) else $error("imem_addr_o not word aligned: 0x%08h", imem_addr_i);

  // x0 writes never retire
  wb_idx_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    debug_wb_rd_vld_i |-> debug_wb_rd_idx_i != '0
  ) else $error("retire event reports register x0");

  wb_vld_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(debug_wb_rd_vld_i)
  ) else $error("debug_wb_rd_vld_o is unknown");

endmodule

bind k423_core k423_props u_k423_props (
  .clk_i             ( clk_i             ),
  .arst_n_i          ( arst_n_i          ),
  .imem_addr_i       ( imem_addr_o       ),
  .debug_wb_rd_vld_i ( debug_wb_rd_vld_o ),
  .debug_wb_rd_idx_i ( debug_wb_rd_idx_o )
);

// ==== sim/k423_tb.sv ====
// k423 core testbench with clock, reset, instruction memory, program and retire tables

module k423_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam k423_pkg::addr_t RESET_PC = 32'h0000_0000;
  localparam int RESET_CYCLES = 8;
  localparam int WAIT_LIMIT   = 20;
  localparam int QUIET_CYCLES = 30;

  // major opcodes as the instruction set manual lists them
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  typedef struct packed {
    k423_pkg::addr_t    pc;
    k423_pkg::reg_idx_t idx;
    k423_pkg::xlen_t    val;
  } retire_t;

  logic               clk;
  logic               arst_n;
  k423_pkg::addr_t    imem_addr;
  k423_pkg::inst_t    imem_rdata;
  k423_pkg::addr_t    debug_wb_pc;
  logic               debug_wb_rd_vld;
  k423_pkg::reg_idx_t debug_wb_rd_idx;
  k423_pkg::xlen_t    debug_wb_rd;

  k423_pkg::inst_t    prog [$];
  retire_t            exp_tab [$];

  k423_core #(
    .RESET_PC ( RESET_PC )
  ) UUT (
    .clk_i             ( clk             ),
    .arst_n_i          ( arst_n          ),
    .imem_addr_o       ( imem_addr       ),
    .imem_rdata_i      ( imem_rdata      ),
    .debug_wb_pc_o     ( debug_wb_pc     ),
    .debug_wb_rd_vld_o ( debug_wb_rd_vld ),
    .debug_wb_rd_idx_o ( debug_wb_rd_idx ),
    .debug_wb_rd_o     ( debug_wb_rd     )
  );

  // ------------------------------
  // instruction encoders
  // ------------------------------
  function automatic k423_pkg::inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
  endfunction

  function automatic k423_pkg::inst_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                            input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic k423_pkg::inst_t enc_b(input logic [2:0] f3, input int rs1,
                                            input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic k423_pkg::inst_t enc_j(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
  endfunction

  // words past the program read as addi x0, x0, 0
  function automatic k423_pkg::inst_t fetch_word(input k423_pkg::addr_t addr);
    k423_pkg::addr_t offs;
    offs = addr - RESET_PC;
    if ((offs >> 2) < prog.size()) begin
      return prog[offs >> 2];
    end
    return 32'h0000_0013;
  endfunction

  // ------------------------------
  // program and expected retires
  // ------------------------------
  task automatic load_program();
    prog.push_back(enc_i(OP_IMM, 3'b000, 1, 0, 5));
    prog.push_back(enc_i(OP_IMM, 3'b000, 2, 0, -3));
    prog.push_back(enc_r(7'h00, 3'b000, 3, 1, 2));
    prog.push_back(enc_r(7'h20, 3'b000, 4, 1, 2));
    prog.push_back(enc_r(7'h00, 3'b111, 5, 1, 2));
    prog.push_back(enc_r(7'h00, 3'b110, 6, 1, 2));
    prog.push_back(enc_r(7'h00, 3'b100, 7, 1, 2));
    prog.push_back(enc_r(7'h00, 3'b010, 8, 2, 1));
    prog.push_back(enc_r(7'h00, 3'b011, 9, 2, 1));
    prog.push_back(enc_r(7'h00, 3'b001, 10, 1, 1));
    prog.push_back(enc_r(7'h00, 3'b101, 11, 2, 1));
    prog.push_back(enc_r(7'h20, 3'b101, 12, 2, 1));
    prog.push_back(enc_i(OP_IMM, 3'b111, 13, 2, 'h0f0));
    prog.push_back(enc_i(OP_IMM, 3'b110, 14, 1, 'h100));
    prog.push_back(enc_i(OP_IMM, 3'b100, 15, 1, -1));
    prog.push_back(enc_i(OP_IMM, 3'b010, 16, 1, -2));
    prog.push_back({20'h12345, 5'd17, OP_LUI});
    // dependent chain through execute forwarding
    prog.push_back(enc_i(OP_IMM, 3'b000, 17, 17, 'h678));
    prog.push_back(enc_i(OP_IMM, 3'b000, 18, 17, 1));
    prog.push_back(enc_i(OP_IMM, 3'b000, 18, 18, 1));
    // write to x0 and a load that is not kept
    prog.push_back(enc_i(OP_IMM, 3'b000, 0, 0, 7));
    prog.push_back(enc_i(OP_LOAD, 3'b010, 19, 0, 0));
    prog.push_back(enc_r(7'h00, 3'b000, 19, 0, 1));
    // taken beq, bne, blt and bge skip two writes each
    prog.push_back(enc_b(3'b000, 1, 1, 12));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 1));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 2));
    prog.push_back(enc_b(3'b001, 1, 2, 12));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 3));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 4));
    prog.push_back(enc_b(3'b100, 2, 1, 12));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 5));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 6));
    prog.push_back(enc_b(3'b101, 1, 2, 12));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 7));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 8));
    prog.push_back(enc_j(21, 12));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 9));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 10));
    // none of these four is taken so the write behind each one retires
    prog.push_back(enc_b(3'b000, 1, 2, 12));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 11));
    prog.push_back(enc_b(3'b001, 1, 1, 12));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 12));
    prog.push_back(enc_b(3'b100, 1, 2, 12));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 13));
    prog.push_back(enc_b(3'b101, 2, 1, 12));
    prog.push_back(enc_i(OP_IMM, 3'b000, 20, 0, 14));
    prog.push_back(enc_i(OP_IMM, 3'b000, 22, 21, 4));
    prog.push_back(enc_r(7'h20, 3'b000, 23, 22, 21));
    // park here with rd x0
    prog.push_back(enc_j(0, 0));
  endtask

  task automatic add_expected(input k423_pkg::addr_t pc, input int idx,
                              input k423_pkg::xlen_t val);
    retire_t ent;
    ent.pc  = pc;
    ent.idx = idx[4:0];
    ent.val = val;
    exp_tab.push_back(ent);
  endtask

  task automatic load_expected();
    add_expected(RESET_PC + 32'h00, 1, 32'h0000_0005);
    add_expected(RESET_PC + 32'h04, 2, 32'hffff_fffd);
    add_expected(RESET_PC + 32'h08, 3, 32'h0000_0002);
    add_expected(RESET_PC + 32'h0c, 4, 32'h0000_0008);
    add_expected(RESET_PC + 32'h10, 5, 32'h0000_0005);
    add_expected(RESET_PC + 32'h14, 6, 32'hffff_fffd);
    add_expected(RESET_PC + 32'h18, 7, 32'hffff_fff8);
    // -3 < 5 holds signed but not unsigned
    add_expected(RESET_PC + 32'h1c, 8, 32'h0000_0001);
    add_expected(RESET_PC + 32'h20, 9, 32'h0000_0000);
    add_expected(RESET_PC + 32'h24, 10, 32'h0000_00a0);
    add_expected(RESET_PC + 32'h28, 11, 32'h07ff_ffff);
    add_expected(RESET_PC + 32'h2c, 12, 32'hffff_ffff);
    add_expected(RESET_PC + 32'h30, 13, 32'h0000_00f0);
    add_expected(RESET_PC + 32'h34, 14, 32'h0000_0105);
    add_expected(RESET_PC + 32'h38, 15, 32'hffff_fffa);
    // 5 < -2 fails signed but holds unsigned
    add_expected(RESET_PC + 32'h3c, 16, 32'h0000_0000);
    add_expected(RESET_PC + 32'h40, 17, 32'h1234_5000);
    add_expected(RESET_PC + 32'h44, 17, 32'h1234_5678);
    add_expected(RESET_PC + 32'h48, 18, 32'h1234_5679);
    add_expected(RESET_PC + 32'h4c, 18, 32'h1234_567a);
    add_expected(RESET_PC + 32'h58, 19, 32'h0000_0005);
    // link of the jal at 0x8c
    add_expected(RESET_PC + 32'h8c, 21, RESET_PC + 32'h90);
    add_expected(RESET_PC + 32'h9c, 20, 32'h0000_000b);
    add_expected(RESET_PC + 32'ha4, 20, 32'h0000_000c);
    add_expected(RESET_PC + 32'hac, 20, 32'h0000_000d);
    add_expected(RESET_PC + 32'hb4, 20, 32'h0000_000e);
    add_expected(RESET_PC + 32'hb8, 22, RESET_PC + 32'h94);
    add_expected(RESET_PC + 32'hbc, 23, 32'h0000_0004);
  endtask

  // ------------------------------
  // checks
  // ------------------------------
  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH at %0d ns: %s expected 0x%08h got 0x%08h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic wait_retire();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!debug_wb_rd_vld && cycles < WAIT_LIMIT);
    assert (debug_wb_rd_vld) else begin
      $display("ERROR at %0d ns: no retire event within %0d cycles", $time, WAIT_LIMIT);
      abort_run();
    end
  endtask

  // ------------------------------
  // clock and instruction memory
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // same cycle read driven 1 ns after the edge
  initial begin
    imem_rdata = 32'h0000_0013;
    forever begin
      @(posedge clk);
      #1;
      imem_rdata = fetch_word(imem_addr);
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    arst_n = 1'b0;
    load_program();
    load_expected();

    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_value("debug_wb_rd_vld_o", 32'd0, {31'd0, debug_wb_rd_vld});
      check_value("imem_addr_o", RESET_PC, imem_addr);
    end
    arst_n = 1'b1;
    check_value("imem_addr_o", RESET_PC, imem_addr);

    foreach (exp_tab[i]) begin
      wait_retire();
      check_value("debug_wb_pc_o", exp_tab[i].pc, debug_wb_pc);
      check_value("debug_wb_rd_idx_o", {27'd0, exp_tab[i].idx}, {27'd0, debug_wb_rd_idx});
      check_value("debug_wb_rd_o", exp_tab[i].val, debug_wb_rd);
    end

    // the closing jal loop must stay silent
    repeat (QUIET_CYCLES) begin
      @(posedge clk);
      #1;
      assert (!debug_wb_rd_vld) else begin
        $display("ERROR at %0d ns: unexpected retire of x%0d from pc 0x%08h",
                 $time, debug_wb_rd_idx, debug_wb_pc);
        abort_run();
      end
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== tb.f ====
src/k423_pkg.sv
src/k423_fetch.sv
src/k423_decode.sv
src/k423_regfile.sv
src/k423_execute.sv
src/k423_core.sv
sim/k423_props.sv
sim/k423_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the k423 core testbench

TOP := k423_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module $(TOP) -o k423_sim
	./obj_dir/k423_sim

clean:
	rm -rf obj_dir
